// File: source/mem_ctrl_pkg.sv
package mem_ctrl_pkg;

    // access width of a load or store
    typedef enum logic [1:0] {
        SIZE_B = 2'b00,
        SIZE_H = 2'b01,
        SIZE_W = 2'b10,
        SIZE_D = 2'b11
    } mem_size_e;

    // arbiter sequencing
    typedef enum logic [1:0] {
        ARB_IDLE   = 2'b00,
        ARB_ACCESS = 2'b01,
        ARB_RESP   = 2'b10
    } arb_state_e;

    // master currently owning the sram
    typedef enum logic {
        GNT_FETCH = 1'b0,
        GNT_LSU   = 1'b1
    } grant_e;

    // access latency in clock edges
    typedef logic [3:0] lat_t;

    // cached main memory window, upper bound exclusive
    localparam logic [31:0] MAIN_BASE  = 32'h8000_0000;
    localparam logic [31:0] MAIN_LIMIT = 32'h8800_0000;

endpackage

// File: source/mem_bus_pkg.sv
package mem_bus_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [63:0] data_t;
    typedef logic [7:0]  strb_t;
    typedef logic [31:0] inst_t;

    // fetch master, read only
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } fetch_req_t;

    typedef struct packed {
        logic  done;
        inst_t inst;
    } fetch_rsp_t;

    // load/store master
    typedef struct packed {
        logic                    valid;
        logic                    write;
        mem_ctrl_pkg::mem_size_e size;
        logic                    is_unsigned;
        addr_t                   addr;
        data_t                   wdata;
    } lsu_req_t;

    typedef struct packed {
        logic  done;
        data_t rdata;
    } lsu_rsp_t;

    // one sram access, idx counts 64-bit words
    typedef struct packed {
        logic  en;
        logic  we;
        addr_t idx;
        strb_t strb;
        data_t wdata;
    } sram_req_t;

endpackage

// File: source/data_align.sv
`timescale 1ns/100ps

module data_align (
    input  mem_ctrl_pkg::grant_e    gnt_i,
    input  mem_bus_pkg::fetch_req_t fetch_req_i,
    input  mem_bus_pkg::lsu_req_t   lsu_req_i,
    input  mem_bus_pkg::data_t      sram_rdata_i,
    output mem_bus_pkg::strb_t      lane_strb_o,
    output mem_bus_pkg::data_t      lane_wdata_o,
    output mem_bus_pkg::data_t      load_data_o,
    output mem_bus_pkg::inst_t      inst_o
);
    import mem_bus_pkg::*;
    import mem_ctrl_pkg::*;

    logic [2:0] byte_off;
    strb_t      size_mask;
    data_t      rd_shift;

    assign byte_off = lsu_req_i.addr[2:0];

    // ****************************************
    // store side
    // ****************************************
    // replicate the data so every legal offset finds it in its lane
    always_comb begin
        case (lsu_req_i.size)
            SIZE_B: begin
                size_mask    = 8'h01;
                lane_wdata_o = {8{lsu_req_i.wdata[7:0]}};
            end
            SIZE_H: begin
                size_mask    = 8'h03;
                lane_wdata_o = {4{lsu_req_i.wdata[15:0]}};
            end
            SIZE_W: begin
                size_mask    = 8'h0f;
                lane_wdata_o = {2{lsu_req_i.wdata[31:0]}};
            end
            default: begin
                size_mask    = 8'hff;
                lane_wdata_o = lsu_req_i.wdata;
            end
        endcase
        // fetches never write
        if (gnt_i == GNT_LSU && lsu_req_i.write) begin
            lane_strb_o = size_mask << byte_off;
        end else begin
            lane_strb_o = '0;
        end
    end

    // ****************************************
    // load side
    // ****************************************
    assign rd_shift = sram_rdata_i >> {byte_off, 3'b000};

    always_comb begin
        case (lsu_req_i.size)
            SIZE_B: begin
                load_data_o = lsu_req_i.is_unsigned ? {56'b0, rd_shift[7:0]}
                                                    : {{56{rd_shift[7]}}, rd_shift[7:0]};
            end
            SIZE_H: begin
                load_data_o = lsu_req_i.is_unsigned ? {48'b0, rd_shift[15:0]}
                                                    : {{48{rd_shift[15]}}, rd_shift[15:0]};
            end
            SIZE_W: begin
                load_data_o = lsu_req_i.is_unsigned ? {32'b0, rd_shift[31:0]}
                                                    : {{32{rd_shift[31]}}, rd_shift[31:0]};
            end
            default: begin
                load_data_o = rd_shift;
            end
        endcase
    end

    // addr bit 2 picks the instruction half
    assign inst_o = fetch_req_i.addr[2] ? sram_rdata_i[63:32] : sram_rdata_i[31:0];

endmodule

// File: source/bus_arbiter_fsm.sv
`timescale 1ns/100ps

module bus_arbiter_fsm #(
    parameter int SRAM_WORDS = 256
) (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  mem_bus_pkg::fetch_req_t fetch_req_i,
    input  mem_bus_pkg::lsu_req_t   lsu_req_i,
    input  mem_bus_pkg::strb_t      lane_strb_i,
    input  mem_bus_pkg::data_t      lane_wdata_i,
    input  logic                    expire_i,
    output logic                    timer_start_o,
    output logic                    timer_dev_o,
    output mem_bus_pkg::sram_req_t  sram_req_o,
    output mem_ctrl_pkg::grant_e    gnt_o,
    output logic                    fetch_done_o,
    output logic                    lsu_done_o
);
    import mem_bus_pkg::*;
    import mem_ctrl_pkg::*;

    arb_state_e state_q;
    arb_state_e state_d;
    grant_e     gnt_q;
    grant_e     gnt_d;
    addr_t      pick_addr;
    addr_t      gnt_addr;
    logic       any_valid;
    logic       issue;

    // ****************************************
    // grant, load/store first
    // ****************************************
    assign any_valid = lsu_req_i.valid | fetch_req_i.valid;
    assign gnt_d     = lsu_req_i.valid ? GNT_LSU : GNT_FETCH;
    assign pick_addr = lsu_req_i.valid ? lsu_req_i.addr : fetch_req_i.addr;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ARB_IDLE: begin
                if (any_valid) begin
                    state_d = ARB_ACCESS;
                end
            end
            ARB_ACCESS: begin
                if (expire_i) begin
                    state_d = ARB_RESP;
                end
            end
            default: begin
                state_d = ARB_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ARB_IDLE;
            gnt_q   <= GNT_FETCH;
        end else begin
            state_q <= state_d;
            if (state_q == ARB_IDLE && any_valid) begin
                gnt_q <= gnt_d;
            end
        end
    end

    // region decode, anything outside the window is device space
    assign timer_start_o = (state_q == ARB_IDLE) && any_valid;
    assign timer_dev_o   = (pick_addr < MAIN_BASE) || (pick_addr >= MAIN_LIMIT);

    // ****************************************
    // sram access on expiry
    // ****************************************
    assign gnt_addr = (gnt_q == GNT_LSU) ? lsu_req_i.addr : fetch_req_i.addr;
    assign issue    = (state_q == ARB_ACCESS) && expire_i;

    always_comb begin
        sram_req_o.en    = issue;
        sram_req_o.we    = issue && (gnt_q == GNT_LSU) && lsu_req_i.write;
        // both regions alias onto the same words
        sram_req_o.idx   = addr_t'(gnt_addr[31:3] % SRAM_WORDS);
        sram_req_o.strb  = lane_strb_i;
        sram_req_o.wdata = lane_wdata_i;
    end

    assign gnt_o        = gnt_q;
    assign fetch_done_o = (state_q == ARB_RESP) && (gnt_q == GNT_FETCH);
    assign lsu_done_o   = (state_q == ARB_RESP) && (gnt_q == GNT_LSU);

endmodule

// File: source/access_timer.sv
`timescale 1ns/100ps

module access_timer #(
    parameter mem_ctrl_pkg::lat_t MAIN_LATENCY = 4'd3,
    parameter mem_ctrl_pkg::lat_t DEV_LATENCY  = 4'd6
) (
    input  logic clk,
    input  logic arst_n_i,
    input  logic start_i,
    input  logic dev_i,
    output logic expire_o
);
    import mem_ctrl_pkg::*;

    // zero means idle
    lat_t cnt_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q    <= '0;
            expire_o <= 1'b0;
        end else begin
            expire_o <= 1'b0;
            if (cnt_q != '0) begin
                // start is ignored while counting
                cnt_q <= cnt_q - 1'b1;
                if (cnt_q == lat_t'(1)) begin
                    expire_o <= 1'b1;
                end
            end else if (start_i) begin
                cnt_q <= dev_i ? DEV_LATENCY : MAIN_LATENCY;
            end
        end
    end

endmodule

// File: source/sram_model.sv
`timescale 1ns/100ps

module sram_model #(
    parameter int SRAM_WORDS = 256
) (
    input  logic                   clk,
    input  mem_bus_pkg::sram_req_t req_i,
    output mem_bus_pkg::data_t     rdata_o
);
    import mem_bus_pkg::*;

    localparam int IDX_W = $clog2(SRAM_WORDS);

    data_t            mem [SRAM_WORDS];
    logic [IDX_W-1:0] idx;

    // arbiter already wrapped the index into range
    assign idx = req_i.idx[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (req_i.en) begin
            // byte lanes under strobe
            for (int i = 0; i < 8; i++) begin
                if (req_i.we && req_i.strb[i]) begin
                    mem[idx][i*8 +: 8] <= req_i.wdata[i*8 +: 8];
                end
            end
            // registered read, old contents on a write
            rdata_o <= mem[idx];
        end
    end

endmodule

// File: source/mem_subsys_top.sv
`timescale 1ns/100ps

module mem_subsys_top #(
    parameter mem_ctrl_pkg::lat_t MAIN_LATENCY = 4'd3,
    parameter mem_ctrl_pkg::lat_t DEV_LATENCY  = 4'd6,
    parameter int                 SRAM_WORDS   = 256
) (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  mem_bus_pkg::fetch_req_t fetch_req_i,
    output mem_bus_pkg::fetch_rsp_t fetch_rsp_o,
    input  mem_bus_pkg::lsu_req_t   lsu_req_i,
    output mem_bus_pkg::lsu_rsp_t   lsu_rsp_o
);
    import mem_bus_pkg::*;
    import mem_ctrl_pkg::*;

    strb_t     lane_strb;
    data_t     lane_wdata;
    data_t     load_data;
    data_t     sram_rdata;
    inst_t     inst;
    sram_req_t sram_req;
    grant_e    gnt;
    logic      timer_start;
    logic      timer_dev;
    logic      expire;
    logic      fetch_done;
    logic      lsu_done;

    // ****************************************
    // arbiter and latency timer
    // ****************************************
    bus_arbiter_fsm #(
        .SRAM_WORDS (SRAM_WORDS)
    ) u_arbiter (
        .clk           (clk        ),
        .arst_n_i      (arst_n_i   ),
        .fetch_req_i   (fetch_req_i),
        .lsu_req_i     (lsu_req_i  ),
        .lane_strb_i   (lane_strb  ),
        .lane_wdata_i  (lane_wdata ),
        .expire_i      (expire     ),
        .timer_start_o (timer_start),
        .timer_dev_o   (timer_dev  ),
        .sram_req_o    (sram_req   ),
        .gnt_o         (gnt        ),
        .fetch_done_o  (fetch_done ),
        .lsu_done_o    (lsu_done   )
    );

    access_timer #(
        .MAIN_LATENCY (MAIN_LATENCY),
        .DEV_LATENCY  (DEV_LATENCY )
    ) u_timer (
        .clk      (clk        ),
        .arst_n_i (arst_n_i   ),
        .start_i  (timer_start),
        .dev_i    (timer_dev  ),
        .expire_o (expire     )
    );

    // ****************************************
    // memory and lane logic
    // ****************************************
    sram_model #(
        .SRAM_WORDS (SRAM_WORDS)
    ) u_sram (
        .clk     (clk       ),
        .req_i   (sram_req  ),
        .rdata_o (sram_rdata)
    );

    data_align u_align (
        .gnt_i        (gnt        ),
        .fetch_req_i  (fetch_req_i),
        .lsu_req_i    (lsu_req_i  ),
        .sram_rdata_i (sram_rdata ),
        .lane_strb_o  (lane_strb  ),
        .lane_wdata_o (lane_wdata ),
        .load_data_o  (load_data  ),
        .inst_o       (inst       )
    );

    // response structs
    assign fetch_rsp_o.done  = fetch_done;
    assign fetch_rsp_o.inst  = inst;
    assign lsu_rsp_o.done    = lsu_done;
    assign lsu_rsp_o.rdata   = load_data;

endmodule

// File: tb/mem_subsys_assert.sv
`timescale 1ns/100ps

module mem_subsys_assert (
    input logic                    clk,
    input logic                    arst_n_i,
    input mem_bus_pkg::fetch_req_t fetch_req_i,
    input mem_bus_pkg::fetch_rsp_t fetch_rsp_i,
    input mem_bus_pkg::lsu_req_t   lsu_req_i,
    input mem_bus_pkg::lsu_rsp_t   lsu_rsp_i
);

    // failed assertion count
    int fail_cnt = 0;

    // ****************************************
    // done pulses
    // ****************************************
    a_fetch_done_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
        fetch_rsp_i.done |=> !fetch_rsp_i.done)
        else begin
            $error("fetch done longer than one cycle");
            fail_cnt++;
        end
    a_lsu_done_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
        lsu_rsp_i.done |=> !lsu_rsp_i.done)
        else begin
            $error("lsu done longer than one cycle");
            fail_cnt++;
        end

    a_fetch_done_valid: assert property (@(posedge clk) disable iff (!arst_n_i)
        fetch_rsp_i.done |-> fetch_req_i.valid)
        else begin
            $error("fetch done without valid");
            fail_cnt++;
        end
    a_lsu_done_valid: assert property (@(posedge clk) disable iff (!arst_n_i)
        lsu_rsp_i.done |-> lsu_req_i.valid)
        else begin
            $error("lsu done without valid");
            fail_cnt++;
        end

    // one access in flight at a time
    a_done_exclusive: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(fetch_rsp_i.done && lsu_rsp_i.done))
        else begin
            $error("both done outputs high");
            fail_cnt++;
        end

    // a waiting master holds its request
    a_fetch_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        fetch_req_i.valid && !fetch_rsp_i.done |=> $stable(fetch_req_i))
        else begin
            $error("fetch request changed while waiting");
            fail_cnt++;
        end
    a_lsu_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        lsu_req_i.valid && !lsu_rsp_i.done |=> $stable(lsu_req_i))
        else begin
            $error("lsu request changed while waiting");
            fail_cnt++;
        end

endmodule

bind mem_subsys_top mem_subsys_assert u_assert (
    .clk         (clk        ),
    .arst_n_i    (arst_n_i   ),
    .fetch_req_i (fetch_req_i),
    .fetch_rsp_i (fetch_rsp_o),
    .lsu_req_i   (lsu_req_i  ),
    .lsu_rsp_i   (lsu_rsp_o  )
);

// File: tb/mem_subsys_tb.sv
`timescale 1ns/100ps

module mem_subsys_tb;
    import mem_bus_pkg::*;
    import mem_ctrl_pkg::*;

    localparam lat_t  MAIN_LAT   = 4'd3;
    localparam lat_t  DEV_LAT    = 4'd6;
    localparam int    SRAM_WORDS = 256;
    localparam int    N_WORDS    = 16;
    localparam int    N_RAND     = 24;
    localparam int    N_FETCH    = 16;
    localparam int    N_CONT     = 4;
    localparam int    N_OPS      = 2 * N_WORDS + 2 * N_RAND + N_FETCH + 3 + 2 * N_CONT;
    localparam int    MAX_CYCLES = N_OPS * 2 * (int'(DEV_LAT) + 3);
    // device window base, aliases onto word 0 of the sram
    localparam addr_t DEV_BASE   = 32'h1000_0000;

    logic       clk;
    logic       arst_n;
    fetch_req_t fetch_req;
    fetch_rsp_t fetch_rsp;
    lsu_req_t   lsu_req;
    lsu_rsp_t   lsu_rsp;

    data_t  model_mem [SRAM_WORDS];
    integer seed;
    int     cycle_cnt = 0;
    int     check_cnt = 0;
    int     err_cnt   = 0;
    int     test_err  = 0;
    int     test_cnt  = 0;

    mem_subsys_top #(
        .MAIN_LATENCY (MAIN_LAT  ),
        .DEV_LATENCY  (DEV_LAT   ),
        .SRAM_WORDS   (SRAM_WORDS)
    ) dut (
        .clk         (clk      ),
        .arst_n_i    (arst_n   ),
        .fetch_req_i (fetch_req),
        .fetch_rsp_o (fetch_rsp),
        .lsu_req_i   (lsu_req  ),
        .lsu_rsp_o   (lsu_rsp  )
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: a request was still waiting for done after %0d cycles", cycle_cnt);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // ****************************************
    // reference model
    // ****************************************
    function automatic int word_idx(addr_t addr);
        return int'(addr >> 3) % SRAM_WORDS;
    endfunction

    function automatic int size_bytes(mem_size_e size);
        return 1 << int'(size);
    endfunction

    task automatic model_store(addr_t addr, mem_size_e size, data_t wdata);
        int idx;
        int off;
        idx = word_idx(addr);
        off = addr[2:0];
        for (int i = 0; i < size_bytes(size); i++) begin
            model_mem[idx][(off + i) * 8 +: 8] = wdata[i * 8 +: 8];
        end
    endtask

    function automatic data_t model_load(addr_t addr, mem_size_e size, logic is_unsigned);
        data_t word;
        data_t val;
        int    nb;
        int    off;
        word = model_mem[word_idx(addr)];
        nb   = size_bytes(size);
        off  = addr[2:0];
        val  = '0;
        for (int i = 0; i < 8; i++) begin
            if (i < nb) begin
                val[i * 8 +: 8] = word[(off + i) * 8 +: 8];
            end else if (!is_unsigned && word[(off + nb) * 8 - 1]) begin
                val[i * 8 +: 8] = 8'hff;
            end
        end
        return val;
    endfunction

    function automatic inst_t model_fetch(addr_t addr);
        data_t word;
        word = model_mem[word_idx(addr)];
        return addr[2] ? word[63:32] : word[31:0];
    endfunction

    // naturally aligned address in one of the first N_WORDS words
    function automatic addr_t rand_addr(mem_size_e size, logic dev);
        int w;
        int off;
        w   = $random(seed) & (N_WORDS - 1);
        off = ($random(seed) & 7) & ~(size_bytes(size) - 1);
        return (dev ? DEV_BASE : MAIN_BASE) + addr_t'(w * 8 + off);
    endfunction

    // ****************************************
    // checks
    // ****************************************
    task automatic check_data(string name, data_t exp, data_t act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            test_err++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_inst(string name, inst_t exp, inst_t act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            test_err++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_lat(string name, lat_t exp, lat_t act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            test_err++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic report_failure(string what);
        check_cnt++;
        err_cnt++;
        test_err++;
        $display("%s", what);
    endtask

    task automatic end_test(string name);
        test_cnt++;
        if (test_err == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_err);
        end
        test_err = 0;
    endtask

    // ****************************************
    // port drivers, called 1 ns after a rising edge
    // ****************************************
    task automatic lsu_access(input logic write, input mem_size_e size, input logic is_unsigned,
                              input addr_t addr, input data_t wdata,
                              output data_t rdata, output lat_t edges);
        int n;
        lsu_req = '{valid: 1'b1, write: write, size: size, is_unsigned: is_unsigned,
                    addr: addr, wdata: wdata};
        n = 0;
        do begin
            @(posedge clk);
            n++;
            @(negedge clk);
        end while (!lsu_rsp.done);
        rdata = lsu_rsp.rdata;
        // edges counted from the accepting edge, saturated at the top of lat_t
        edges = (n > 16) ? lat_t'(15) : lat_t'(n - 1);
        @(posedge clk);
        #1;
        lsu_req.valid = 1'b0;
    endtask

    task automatic fetch_access(input addr_t addr, output inst_t inst);
        fetch_req = '{valid: 1'b1, addr: addr};
        do begin
            @(posedge clk);
            @(negedge clk);
        end while (!fetch_rsp.done);
        inst = fetch_rsp.inst;
        @(posedge clk);
        #1;
        fetch_req.valid = 1'b0;
    endtask

    // both ports raised together, each dropped the cycle after its own done
    task automatic dual_access(input logic write, input mem_size_e size, input addr_t lsu_addr,
                               input data_t wdata, input addr_t fetch_addr,
                               output data_t rdata, output inst_t inst, output logic lsu_first);
        int n;
        int lsu_at;
        int fetch_at;
        lsu_req   = '{valid: 1'b1, write: write, size: size, is_unsigned: 1'b0,
                      addr: lsu_addr, wdata: wdata};
        fetch_req = '{valid: 1'b1, addr: fetch_addr};
        n        = 0;
        lsu_at   = 0;
        fetch_at = 0;
        while (lsu_at == 0 || fetch_at == 0) begin
            @(posedge clk);
            #1;
            if (lsu_at != 0) begin
                lsu_req.valid = 1'b0;
            end
            if (fetch_at != 0) begin
                fetch_req.valid = 1'b0;
            end
            @(negedge clk);
            n++;
            if (lsu_rsp.done && lsu_at == 0) begin
                lsu_at = n;
                rdata  = lsu_rsp.rdata;
            end
            if (fetch_rsp.done && fetch_at == 0) begin
                fetch_at = n;
                inst     = fetch_rsp.inst;
            end
        end
        lsu_first = lsu_at < fetch_at;
        @(posedge clk);
        #1;
        lsu_req.valid   = 1'b0;
        fetch_req.valid = 1'b0;
    endtask

    // ****************************************
    // test sequence
    // ****************************************
    initial begin
        data_t     rdata;
        data_t     wdata;
        inst_t     inst;
        lat_t      edges;
        mem_size_e size;
        logic      uns;
        logic      lsu_first;
        addr_t     addr;
        seed      = 83435;
        clk       = 1'b0;
        arst_n    = 1'b0;
        fetch_req = '0;
        lsu_req   = '0;
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;

        repeat (4) begin
            @(negedge clk);
            if (fetch_rsp.done || lsu_rsp.done) begin
                report_failure("done went high while no request was valid");
            end
        end
        @(posedge clk);
        #1;
        end_test("reset_idle");

        for (int w = 0; w < N_WORDS; w++) begin
            wdata = {$random(seed), $random(seed)};
            model_store(MAIN_BASE + addr_t'(w * 8), SIZE_D, wdata);
            lsu_access(1'b1, SIZE_D, 1'b0, MAIN_BASE + addr_t'(w * 8), wdata, rdata, edges);
        end
        for (int w = 0; w < N_WORDS; w++) begin
            lsu_access(1'b0, SIZE_D, 1'b0, MAIN_BASE + addr_t'(w * 8), '0, rdata, edges);
            check_data("dword_init", model_load(MAIN_BASE + addr_t'(w * 8), SIZE_D, 1'b0), rdata);
        end
        end_test("dword_init");

        for (int i = 0; i < N_RAND; i++) begin
            size  = mem_size_e'({$random(seed)} % 3);
            addr  = rand_addr(size, $random(seed) & 1);
            wdata = {$random(seed), $random(seed)};
            model_store(addr, size, wdata);
            lsu_access(1'b1, size, 1'b0, addr, wdata, rdata, edges);
            size = mem_size_e'($random(seed) & 3);
            uns  = $random(seed) & 1;
            addr = rand_addr(size, $random(seed) & 1);
            lsu_access(1'b0, size, uns, addr, '0, rdata, edges);
            check_data("sub_word", model_load(addr, size, uns), rdata);
        end
        end_test("sub_word");

        for (int i = 0; i < N_FETCH; i++) begin
            addr = MAIN_BASE + addr_t'(($random(seed) & (N_WORDS - 1)) * 8 + ($random(seed) & 4));
            fetch_access(addr, inst);
            check_inst("fetch", model_fetch(addr), inst);
        end
        end_test("fetch");

        // lone accesses, the device ones alias onto main word 3
        lsu_access(1'b0, SIZE_D, 1'b0, MAIN_BASE + 32'h18, '0, rdata, edges);
        check_lat("lat_main", lat_t'(MAIN_LAT + 1), edges);
        check_data("lat_main", model_load(MAIN_BASE + 32'h18, SIZE_D, 1'b0), rdata);
        model_store(DEV_BASE + 32'h1c, SIZE_W, 64'h0000_0000_cafe_f00d);
        lsu_access(1'b1, SIZE_W, 1'b0, DEV_BASE + 32'h1c, 64'hcafe_f00d, rdata, edges);
        check_lat("lat_dev_store", lat_t'(DEV_LAT + 1), edges);
        lsu_access(1'b0, SIZE_D, 1'b0, DEV_BASE + 32'h18, '0, rdata, edges);
        check_lat("lat_dev_load", lat_t'(DEV_LAT + 1), edges);
        check_data("dev_alias", model_load(MAIN_BASE + 32'h18, SIZE_D, 1'b0), rdata);
        end_test("latency");

        for (int i = 0; i < N_CONT; i++) begin
            size  = mem_size_e'({$random(seed)} % 3);
            addr  = rand_addr(size, 1'b0);
            wdata = {$random(seed), $random(seed)};
            // load/store wins, so a store lands before the fetch reads
            if (i % 2 == 0) begin
                model_store(addr, size, wdata);
            end
            dual_access(i % 2 == 0, size, addr, wdata, {addr[31:3], 3'b000} | ($random(seed) & 4),
                        rdata, inst, lsu_first);
            if (!lsu_first) begin
                report_failure("fetch finished before the load/store request in the same cycle");
            end
            if (i % 2 != 0) begin
                check_data("contention_lsu", model_load(addr, size, 1'b0), rdata);
            end
            check_inst("contention_fetch", model_fetch(fetch_req.addr), inst);
        end
        end_test("contention");

        // handshake assertions in the bound checker
        if (dut.u_assert.fail_cnt != 0) begin
            report_failure($sformatf("%0d handshake assertions failed", dut.u_assert.fail_cnt));
        end

        $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
source/mem_ctrl_pkg.sv
source/mem_bus_pkg.sv
source/data_align.sv
source/bus_arbiter_fsm.sv
source/access_timer.sv
source/sram_model.sv
source/mem_subsys_top.sv
tb/mem_subsys_assert.sv
tb/mem_subsys_tb.sv
